//--- source/sqz_pkg.sv
package sqz_pkg;

	// ------------------------------------------------------------
	// sizes scaled down for short simulations
	// ------------------------------------------------------------
	localparam int WORD_W          = 32;
	localparam int BLOCK_SIZE      = 16;	// words per host block
	localparam int FIFO_DEPTH      = 64;
	localparam int FIFO_PTR_W      = 6;
	localparam int FIFO_CNT_W      = 7;	// holds 0 to FIFO_DEPTH
	localparam int BUFFER_HEADROOM = 4;	// slack for the count latency
	localparam int MEM_WORDS       = 256;
	localparam int MEM_AW          = 8;
	localparam int CMD_WORDS       = 4;
	localparam int CMD_IDX_W       = 2;
	localparam int CMD_CNT_W       = 3;	// holds 0 to CMD_WORDS
	localparam int NBLK_W          = 16;
	localparam int XCNT_W          = 20;	// word count of one transfer
	localparam int SKID_DEPTH      = 4;	// memory reads in flight plus parked
	localparam int SKID_PTR_W      = 2;
	localparam int SKID_CNT_W      = 3;
	localparam int WIRE_AW         = 3;

	// command slots
	localparam int SLOT_SHAPE = 0;
	localparam int SLOT_XFER  = 1;
	localparam int SLOT_DATA  = 2;

	localparam logic [WIRE_AW-1:0] WIRE_STATUS = 3'd4;	// irq in bit 0

	typedef enum logic [2:0] {
		OP_NONE  = 3'd0,
		OP_WRITE = 3'd1,	// pipe-in to memory
		OP_READ  = 3'd2	// memory to pipe-out
	} op_type_e;

	// ------------------------------------------------------------
	// command word views
	// ------------------------------------------------------------
	typedef struct packed {
		logic [7:0] o_side;
		logic [7:0] i_side;
		logic [7:0] kernel;
		logic [3:0] stride;
		logic       rsvd;
		op_type_e   op_type;
	} shape_t;

	typedef struct packed {
		logic [15:0]       o_channel;
		logic [NBLK_W-1:0] nblocks;
	} xfer_fld_t;

	typedef struct packed {
		logic [1:0]  rsvd;
		logic [29:0] start_addr;
	} addr_fld_t;

	typedef union packed {
		logic [WORD_W-1:0] raw;
		shape_t            shape;
		xfer_fld_t         xfer;
		addr_fld_t         addr;
	} cmd_word_u;

	// one transfer from csb to dma_port
	typedef struct packed {
		logic              dir;	// set for memory to pipe-out
		logic [MEM_AW-1:0] addr;
		logic [NBLK_W-1:0] nblocks;
	} xfer_t;

endpackage

//--- source/pipe_fifo.sv
`timescale 1ns/10ps
module pipe_fifo (
	input  logic                              okClk,
	input  logic                              i_reset,
	input  logic                              i_wr_en,
	input  logic [sqz_pkg::WORD_W-1:0]        i_wr_data,
	input  logic                              i_rd_en,
	output logic [sqz_pkg::WORD_W-1:0]        o_rd_data,
	output logic                              o_rd_valid,
	output logic [sqz_pkg::FIFO_CNT_W-1:0]    o_count,
	output logic                              o_full,
	output logic                              o_empty
);

	logic [sqz_pkg::WORD_W-1:0]     mem [sqz_pkg::FIFO_DEPTH];
	logic [sqz_pkg::FIFO_PTR_W-1:0] wr_ptr;
	logic [sqz_pkg::FIFO_PTR_W-1:0] rd_ptr;
	logic                           wr_ok;
	logic                           rd_ok;

	assign o_full  = (o_count == sqz_pkg::FIFO_CNT_W'(sqz_pkg::FIFO_DEPTH));
	assign o_empty = (o_count == '0);
	assign wr_ok   = i_wr_en && !o_full;	// push to a full fifo is dropped
	assign rd_ok   = i_rd_en && !o_empty;

	always_ff @(posedge okClk) begin
		if (i_reset) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			o_count    <= '0;
			o_rd_valid <= 1'b0;
		end else begin
			o_rd_valid <= rd_ok;	// data follows one cycle after the pop
			if (wr_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_ok)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_ok, rd_ok})
				2'b10:   o_count <= o_count + 1'b1;
				2'b01:   o_count <= o_count - 1'b1;
				default: o_count <= o_count;
			endcase
		end
	end

	always_ff @(posedge okClk) begin
		if (wr_ok)
			mem[wr_ptr] <= i_wr_data;
		if (rd_ok)
			o_rd_data <= mem[rd_ptr];
	end

endmodule

//--- source/host_endpoints.sv
`timescale 1ns/10ps
module host_endpoints (
	input  logic                                            okClk,
	input  logic                                            i_reset,
	input  logic                                            i_pipe_in_write,
	input  logic [sqz_pkg::WORD_W-1:0]                      i_pipe_in_data,
	input  logic                                            i_pipe_out_read,
	input  logic                                            i_csb_owns_in,
	input  logic                                            i_csb_rd,
	input  logic                                            i_dma_rd,
	input  logic                                            i_dma_wr,
	input  logic [sqz_pkg::WORD_W-1:0]                      i_dma_wr_data,
	input  sqz_pkg::cmd_word_u [sqz_pkg::CMD_WORDS-1:0]     i_cmd,
	input  logic                                            i_irq,
	input  logic [sqz_pkg::WIRE_AW-1:0]                     i_wire_addr,
	output logic                                            o_pipe_in_ready,
	output logic                                            o_pipe_out_ready,
	output logic [sqz_pkg::WORD_W-1:0]                      o_pipe_out_data,
	output logic                                            o_pipe_out_valid,
	output logic [sqz_pkg::WORD_W-1:0]                      o_in_data,
	output logic                                            o_in_valid,
	output logic                                            o_in_empty,
	output logic                                            o_out_full,
	output logic [sqz_pkg::WORD_W-1:0]                      o_wire_data
);

	logic                           in_rd;
	logic [sqz_pkg::FIFO_CNT_W-1:0] in_count;
	logic [sqz_pkg::FIFO_CNT_W-1:0] out_count;

	assign in_rd = i_csb_owns_in ? i_csb_rd : i_dma_rd;	// csb only while loading

	pipe_fifo u_pipe_in (
		.okClk		(okClk),
		.i_reset	(i_reset),
		.i_wr_en	(i_pipe_in_write),
		.i_wr_data	(i_pipe_in_data),
		.i_rd_en	(in_rd),
		.o_rd_data	(o_in_data),
		.o_rd_valid	(o_in_valid),
		.o_count	(in_count),
		.o_full		(),
		.o_empty	(o_in_empty)
	);

	pipe_fifo u_pipe_out (
		.okClk		(okClk),
		.i_reset	(i_reset),
		.i_wr_en	(i_dma_wr),
		.i_wr_data	(i_dma_wr_data),
		.i_rd_en	(i_pipe_out_read),
		.o_rd_data	(o_pipe_out_data),
		.o_rd_valid	(o_pipe_out_valid),
		.o_count	(out_count),
		.o_full		(o_out_full),
		.o_empty	()
	);

	// ------------------------------------------------------------
	// block throttle
	// ------------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (i_reset) begin
			o_pipe_in_ready  <= 1'b0;
			o_pipe_out_ready <= 1'b0;
		end else begin
			// room for one more block less the headroom
			o_pipe_in_ready  <= (in_count <= sqz_pkg::FIFO_CNT_W'(sqz_pkg::FIFO_DEPTH
				- sqz_pkg::BUFFER_HEADROOM - sqz_pkg::BLOCK_SIZE));
			o_pipe_out_ready <= (out_count >= sqz_pkg::FIFO_CNT_W'(sqz_pkg::BLOCK_SIZE));
		end
	end

	always_comb begin
		o_wire_data = '0;
		if (i_wire_addr < sqz_pkg::WIRE_AW'(sqz_pkg::CMD_WORDS))
			o_wire_data = i_cmd[i_wire_addr[sqz_pkg::CMD_IDX_W-1:0]].raw;	// command slots
		else if (i_wire_addr == sqz_pkg::WIRE_STATUS)
			o_wire_data[0] = i_irq;
	end

endmodule

//--- source/csb.sv
`timescale 1ns/10ps
module csb (
	input  logic                                            okClk,
	input  logic                                            i_reset,
	input  logic                                            i_op_en,
	input  logic [sqz_pkg::WORD_W-1:0]                      i_in_data,
	input  logic                                            i_in_valid,
	input  logic                                            i_in_empty,
	input  logic                                            i_xfer_ack,
	output logic                                            o_owns_in,
	output logic                                            o_in_rd,
	output sqz_pkg::cmd_word_u [sqz_pkg::CMD_WORDS-1:0]     o_cmd,
	output sqz_pkg::xfer_t                                  o_xfer,
	output logic                                            o_xfer_req,
	output logic                                            o_irq
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOAD,
		ST_ISSUE,
		ST_WAIT_ACK,
		ST_RELEASE,
		ST_DONE
	} state_e;

	state_e                        state;
	logic                          op_en_q;
	logic [sqz_pkg::CMD_CNT_W-1:0] pop_cnt;	// words requested from pipe-in
	logic [sqz_pkg::CMD_CNT_W-1:0] rx_cnt;	// words landed in the slots
	sqz_pkg::op_type_e             op_type;
	logic [sqz_pkg::NBLK_W-1:0]    nblocks;
	logic                          xfer_ok;

	// ------------------------------------------------------------
	// field decode
	// ------------------------------------------------------------
	assign op_type = o_cmd[sqz_pkg::SLOT_SHAPE].shape.op_type;
	assign nblocks = o_cmd[sqz_pkg::SLOT_XFER].xfer.nblocks;
	assign xfer_ok = (op_type == sqz_pkg::OP_WRITE || op_type == sqz_pkg::OP_READ)
		&& (nblocks != '0);

	assign o_xfer.dir     = (op_type == sqz_pkg::OP_READ);
	assign o_xfer.addr    = o_cmd[sqz_pkg::SLOT_DATA].addr.start_addr[sqz_pkg::MEM_AW-1:0];
	assign o_xfer.nblocks = nblocks;

	assign o_owns_in  = (state == ST_LOAD);
	assign o_in_rd    = o_owns_in && !i_in_empty
		&& (pop_cnt < sqz_pkg::CMD_CNT_W'(sqz_pkg::CMD_WORDS));
	assign o_xfer_req = (state == ST_WAIT_ACK);
	assign o_irq      = (state == ST_DONE);

	always_ff @(posedge okClk) begin
		if (i_reset) begin
			state   <= ST_IDLE;
			op_en_q <= 1'b0;
			pop_cnt <= '0;
			rx_cnt  <= '0;
		end else begin
			op_en_q <= i_op_en;
			case (state)
				ST_IDLE: begin
					if (i_op_en && !op_en_q) begin	// rising edge starts a command
						state   <= ST_LOAD;
						pop_cnt <= '0;
						rx_cnt  <= '0;
					end
				end
				ST_LOAD: begin
					if (o_in_rd)
						pop_cnt <= pop_cnt + 1'b1;
					if (i_in_valid) begin
						rx_cnt <= rx_cnt + 1'b1;
						if (rx_cnt == sqz_pkg::CMD_CNT_W'(sqz_pkg::CMD_WORDS - 1))
							state <= ST_ISSUE;	// last slot arrives now
					end
				end
				ST_ISSUE:    state <= xfer_ok ? ST_WAIT_ACK : ST_DONE;
				ST_WAIT_ACK: if (i_xfer_ack) state <= ST_RELEASE;
				ST_RELEASE:  if (!i_xfer_ack) state <= ST_DONE;	// ack low closes the handshake
				ST_DONE:     if (!i_op_en) state <= ST_IDLE;
				default:     state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge okClk) begin
		if (state == ST_LOAD && i_in_valid)
			o_cmd[rx_cnt[sqz_pkg::CMD_IDX_W-1:0]].raw <= i_in_data;
	end

endmodule

//--- source/dma_port.sv
`timescale 1ns/10ps
module dma_port (
	input  logic                           okClk,
	input  logic                           i_reset,
	input  sqz_pkg::xfer_t                 i_xfer,
	input  logic                           i_xfer_req,
	input  logic [sqz_pkg::WORD_W-1:0]     i_in_data,
	input  logic                           i_in_valid,
	input  logic                           i_in_empty,
	input  logic                           i_out_full,
	input  logic [sqz_pkg::WORD_W-1:0]     i_mem_rd_data,
	output logic                           o_xfer_ack,
	output logic                           o_in_rd,
	output logic                           o_out_wr,
	output logic [sqz_pkg::WORD_W-1:0]     o_out_data,
	output logic                           o_mem_en,
	output logic                           o_mem_we,
	output logic [sqz_pkg::MEM_AW-1:0]     o_mem_addr,
	output logic [sqz_pkg::WORD_W-1:0]     o_mem_wr_data
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_RUN,
		ST_ACK
	} state_e;

	state_e                         state;
	sqz_pkg::xfer_t                 xfer_q;
	logic [sqz_pkg::XCNT_W-1:0]     total;
	logic [sqz_pkg::XCNT_W-1:0]     issue_cnt;	// pops or memory reads issued
	logic [sqz_pkg::XCNT_W-1:0]     done_cnt;	// words stored or sent out
	logic                           issue;
	logic                           store;
	logic                           mem_valid;
	logic [sqz_pkg::WORD_W-1:0]     skid [sqz_pkg::SKID_DEPTH];
	logic [sqz_pkg::SKID_PTR_W-1:0] skid_wr;
	logic [sqz_pkg::SKID_PTR_W-1:0] skid_rd;
	logic [sqz_pkg::SKID_CNT_W-1:0] skid_cnt;

	// reads in flight plus parked words never exceed the skid depth
	assign issue = (state == ST_RUN) && (issue_cnt != total)
		&& (xfer_q.dir ? ((skid_cnt + mem_valid) < sqz_pkg::SKID_DEPTH) : !i_in_empty);
	assign store = (state == ST_RUN) && !xfer_q.dir && i_in_valid;

	assign o_in_rd       = issue && !xfer_q.dir;
	assign o_mem_en      = (issue && xfer_q.dir) || store;
	assign o_mem_we      = store;
	assign o_mem_addr    = xfer_q.addr + (store ? done_cnt[sqz_pkg::MEM_AW-1:0]
		: issue_cnt[sqz_pkg::MEM_AW-1:0]);
	assign o_mem_wr_data = i_in_data;
	assign o_out_wr      = (skid_cnt != '0) && !i_out_full;	// stall on a full pipe-out
	assign o_out_data    = skid[skid_rd];
	assign o_xfer_ack    = (state == ST_ACK);

	always_ff @(posedge okClk) begin
		if (i_reset) begin
			state     <= ST_IDLE;
			issue_cnt <= '0;
			done_cnt  <= '0;
			mem_valid <= 1'b0;
			skid_wr   <= '0;
			skid_rd   <= '0;
			skid_cnt  <= '0;
		end else begin
			mem_valid <= issue && xfer_q.dir;	// one cycle memory latency
			if (issue)
				issue_cnt <= issue_cnt + 1'b1;
			if (store || o_out_wr)
				done_cnt <= done_cnt + 1'b1;
			if (mem_valid)
				skid_wr <= skid_wr + 1'b1;
			if (o_out_wr)
				skid_rd <= skid_rd + 1'b1;
			case ({mem_valid, o_out_wr})
				2'b10:   skid_cnt <= skid_cnt + 1'b1;
				2'b01:   skid_cnt <= skid_cnt - 1'b1;
				default: skid_cnt <= skid_cnt;
			endcase
			case (state)
				ST_IDLE: begin
					if (i_xfer_req) begin
						state     <= ST_RUN;
						issue_cnt <= '0;
						done_cnt  <= '0;
					end
				end
				ST_RUN:  if (done_cnt == total) state <= ST_ACK;
				ST_ACK:  if (!i_xfer_req) state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge okClk) begin
		if (state == ST_IDLE && i_xfer_req) begin
			xfer_q <= i_xfer;
			total  <= sqz_pkg::XCNT_W'(i_xfer.nblocks) * sqz_pkg::XCNT_W'(sqz_pkg::BLOCK_SIZE);
		end
		if (mem_valid)
			skid[skid_wr] <= i_mem_rd_data;
	end

endmodule

//--- source/scratch_mem.sv
`timescale 1ns/10ps
module scratch_mem (
	input  logic                          okClk,
	input  logic                          i_en,
	input  logic                          i_we,
	input  logic [sqz_pkg::MEM_AW-1:0]    i_addr,
	input  logic [sqz_pkg::WORD_W-1:0]    i_wr_data,
	output logic [sqz_pkg::WORD_W-1:0]    o_rd_data
);

	logic [sqz_pkg::WORD_W-1:0] mem [sqz_pkg::MEM_WORDS];

	always_ff @(posedge okClk) begin
		if (i_en) begin
			if (i_we)
				mem[i_addr] <= i_wr_data;
			else
				o_rd_data <= mem[i_addr];	// valid the next cycle
		end
	end

endmodule

//--- source/sqz_top.sv
`timescale 1ns/10ps
module sqz_top (
	input  logic                           okClk,
	input  logic                           i_reset,
	input  logic                           i_pipe_in_write,
	input  logic [sqz_pkg::WORD_W-1:0]     i_pipe_in_data,
	output logic                           o_pipe_in_ready,
	input  logic                           i_pipe_out_read,
	output logic [sqz_pkg::WORD_W-1:0]     o_pipe_out_data,
	output logic                           o_pipe_out_valid,
	output logic                           o_pipe_out_ready,
	input  logic                           i_op_en,
	output logic                           o_irq,
	input  logic [sqz_pkg::WIRE_AW-1:0]    i_wire_addr,
	output logic [sqz_pkg::WORD_W-1:0]     o_wire_data
);

	sqz_pkg::cmd_word_u [sqz_pkg::CMD_WORDS-1:0] cmd;
	sqz_pkg::xfer_t                              xfer;
	logic                                        xfer_req;
	logic                                        xfer_ack;
	logic                                        csb_owns_in;
	logic                                        csb_rd;
	logic                                        dma_rd;
	logic                                        dma_wr;
	logic [sqz_pkg::WORD_W-1:0]                  dma_wr_data;
	logic [sqz_pkg::WORD_W-1:0]                  in_data;
	logic                                        in_valid;
	logic                                        in_empty;
	logic                                        out_full;
	logic                                        mem_en;
	logic                                        mem_we;
	logic [sqz_pkg::MEM_AW-1:0]                  mem_addr;
	logic [sqz_pkg::WORD_W-1:0]                  mem_wr_data;
	logic [sqz_pkg::WORD_W-1:0]                  mem_rd_data;

	host_endpoints u_host_endpoints (
		.okClk			(okClk),
		.i_reset		(i_reset),
		.i_pipe_in_write	(i_pipe_in_write),
		.i_pipe_in_data		(i_pipe_in_data),
		.i_pipe_out_read	(i_pipe_out_read),
		.i_csb_owns_in		(csb_owns_in),
		.i_csb_rd		(csb_rd),
		.i_dma_rd		(dma_rd),
		.i_dma_wr		(dma_wr),
		.i_dma_wr_data		(dma_wr_data),
		.i_cmd			(cmd),
		.i_irq			(o_irq),
		.i_wire_addr		(i_wire_addr),
		.o_pipe_in_ready	(o_pipe_in_ready),
		.o_pipe_out_ready	(o_pipe_out_ready),
		.o_pipe_out_data	(o_pipe_out_data),
		.o_pipe_out_valid	(o_pipe_out_valid),
		.o_in_data		(in_data),
		.o_in_valid		(in_valid),
		.o_in_empty		(in_empty),
		.o_out_full		(out_full),
		.o_wire_data		(o_wire_data)
	);

	// ------------------------------------------------------------
	// control and data movement
	// ------------------------------------------------------------
	csb u_csb (
		.okClk		(okClk),
		.i_reset	(i_reset),
		.i_op_en	(i_op_en),
		.i_in_data	(in_data),
		.i_in_valid	(in_valid),
		.i_in_empty	(in_empty),
		.i_xfer_ack	(xfer_ack),
		.o_owns_in	(csb_owns_in),
		.o_in_rd	(csb_rd),
		.o_cmd		(cmd),
		.o_xfer		(xfer),
		.o_xfer_req	(xfer_req),
		.o_irq		(o_irq)
	);

	dma_port u_dma_port (
		.okClk		(okClk),
		.i_reset	(i_reset),
		.i_xfer		(xfer),
		.i_xfer_req	(xfer_req),
		.i_in_data	(in_data),
		.i_in_valid	(in_valid),
		.i_in_empty	(in_empty),
		.i_out_full	(out_full),
		.i_mem_rd_data	(mem_rd_data),
		.o_xfer_ack	(xfer_ack),
		.o_in_rd	(dma_rd),
		.o_out_wr	(dma_wr),
		.o_out_data	(dma_wr_data),
		.o_mem_en	(mem_en),
		.o_mem_we	(mem_we),
		.o_mem_addr	(mem_addr),
		.o_mem_wr_data	(mem_wr_data)
	);

	scratch_mem u_scratch_mem (
		.okClk		(okClk),
		.i_en		(mem_en),
		.i_we		(mem_we),
		.i_addr		(mem_addr),
		.i_wr_data	(mem_wr_data),
		.o_rd_data	(mem_rd_data)
	);

endmodule

//--- dv/tb_sqz_top.sv
`timescale 1ns/10ps
module tb_sqz_top;

	typedef struct packed {
		sqz_pkg::op_type_e op;
		logic [7:0]        addr;	// word address in scratch memory
		logic [15:0]       nblocks;
		logic              stall;	// host holds off pipe-out reads
	} row_t;

	logic                       okClk;
	logic                       i_reset;
	logic                       i_pipe_in_write;
	logic [31:0]                i_pipe_in_data;
	logic                       o_pipe_in_ready;
	logic                       i_pipe_out_read;
	logic [31:0]                o_pipe_out_data;
	logic                       o_pipe_out_valid;
	logic                       o_pipe_out_ready;
	logic                       i_op_en;
	logic                       o_irq;
	logic [2:0]                 i_wire_addr;
	logic [31:0]                o_wire_data;

	logic [31:0] ref_mem [256];	// mirror of the scratch memory
	logic [31:0] exp_q [$];	// words expected on pipe-out in order
	int          err_cnt;
	int          check_cnt;
	int          cycle_cnt;
	int          cycle_limit;
	int          total_words;

	// ------------------------------------------------------------
	// operation table applied in order
	// ------------------------------------------------------------
	row_t rows [9] = '{
		'{sqz_pkg::OP_WRITE, 8'h10, 16'd2, 1'b0},
		'{sqz_pkg::OP_READ,  8'h10, 16'd2, 1'b0},
		'{sqz_pkg::OP_WRITE, 8'h40, 16'd5, 1'b0},
		'{sqz_pkg::OP_READ,  8'h40, 16'd5, 1'b1},	// 80 words is more than the fifo holds
		'{sqz_pkg::OP_NONE,  8'h00, 16'd3, 1'b0},
		'{sqz_pkg::OP_READ,  8'h18, 16'd1, 1'b0},
		'{sqz_pkg::OP_WRITE, 8'hf8, 16'd1, 1'b0},	// wraps past the top address
		'{sqz_pkg::OP_READ,  8'hf8, 16'd1, 1'b0},
		'{sqz_pkg::OP_READ,  8'h20, 16'd0, 1'b0}	// zero blocks means no transfer
	};

	sqz_top u_sqz_top (
		.okClk            (okClk),
		.i_reset          (i_reset),
		.i_pipe_in_write  (i_pipe_in_write),
		.i_pipe_in_data   (i_pipe_in_data),
		.o_pipe_in_ready  (o_pipe_in_ready),
		.i_pipe_out_read  (i_pipe_out_read),
		.o_pipe_out_data  (o_pipe_out_data),
		.o_pipe_out_valid (o_pipe_out_valid),
		.o_pipe_out_ready (o_pipe_out_ready),
		.i_op_en          (i_op_en),
		.o_irq            (o_irq),
		.i_wire_addr      (i_wire_addr),
		.o_wire_data      (o_wire_data)
	);

	initial okClk = 1'b0;
	always #10 okClk = ~okClk;

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		check_cnt++;
		if (actual !== expected) begin
			err_cnt++;
			$display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic tick();
		@(posedge okClk);
		#1;	// drive and sample just after the edge
	endtask

	task automatic apply_reset();
		i_reset = 1'b1;
		repeat (10) tick();
		i_reset = 1'b0;
		repeat (2) tick();	// in_ready comes up one cycle after release
	endtask

	task automatic push_word(input logic [31:0] word);
		i_pipe_in_write = 1'b1;
		i_pipe_in_data  = word;
		tick();
		i_pipe_in_write = 1'b0;
	endtask

	task automatic read_block();
		while (!o_pipe_out_ready)
			tick();
		i_pipe_out_read = 1'b1;
		repeat (sqz_pkg::BLOCK_SIZE) tick();
		i_pipe_out_read = 1'b0;
		repeat (2) tick();	// last valid lands and the ready flag catches up
	endtask

	// ------------------------------------------------------------
	// one table row with command, data, interrupt, readback and release
	// ------------------------------------------------------------
	task automatic run_row(input row_t r);
		logic [31:0] cmd_w [4];
		logic [31:0] word;
		int          n_words;

		cmd_w[0] = {8'($urandom), 8'($urandom), 8'($urandom), 4'($urandom), 1'b0, 3'(r.op)};
		cmd_w[1] = {16'($urandom), r.nblocks};
		cmd_w[2] = {2'b00, 22'($urandom), r.addr};	// only the low 8 bits address memory
		cmd_w[3] = $urandom;
		n_words  = int'(r.nblocks) * sqz_pkg::BLOCK_SIZE;

		for (int i = 0; i < sqz_pkg::CMD_WORDS; i++)
			push_word(cmd_w[i]);
		i_op_en = 1'b1;

		if (r.op == sqz_pkg::OP_WRITE) begin
			for (int b = 0; b < int'(r.nblocks); b++) begin
				while (!o_pipe_in_ready)
					tick();
				for (int w = 0; w < sqz_pkg::BLOCK_SIZE; w++) begin
					word = $urandom;
					ref_mem[8'(int'(r.addr) + b * sqz_pkg::BLOCK_SIZE + w)] = word;
					push_word(word);
				end
			end
		end else if (r.op == sqz_pkg::OP_READ) begin
			for (int i = 0; i < n_words; i++)
				exp_q.push_back(ref_mem[8'(int'(r.addr) + i)]);
			if (r.stall) begin
				while (!o_pipe_out_ready)
					tick();
				repeat (100) tick();	// let the dma back up against a full fifo
			end
			for (int b = 0; b < int'(r.nblocks); b++)
				read_block();
		end

		while (!o_irq)
			tick();
		if (r.op != sqz_pkg::OP_READ || r.nblocks == 16'd0) begin
			// pipe-out must be empty here, so a probe read shows any stray word
			i_pipe_out_read = 1'b1;
			tick();
			i_pipe_out_read = 1'b0;
			tick();
		end
		check_value("pipe-out words missing", exp_q.size(), 32'd0);

		for (int a = 0; a < sqz_pkg::CMD_WORDS; a++) begin
			i_wire_addr = 3'(a);
			tick();
			check_value($sformatf("o_wire_data[%0d]", a), o_wire_data, cmd_w[a]);
		end
		i_wire_addr = 3'd4;
		tick();
		check_value("o_wire_data status", o_wire_data, 32'd1);
		i_wire_addr = 3'd0;

		i_op_en = 1'b0;
		repeat (2) tick();
		check_value("o_irq after release", 32'(o_irq), 32'd0);
	endtask

	// pipe-out words are compared as they come
	always @(negedge okClk) begin
		if (o_pipe_out_valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				err_cnt++;
				$display("t=%0t pipe-out produced a word that no read operation asked for",
					$time);
			end else begin
				check_value("o_pipe_out_data", o_pipe_out_data, exp_q.pop_front());
			end
		end
	end

	initial begin : watchdog
		cycle_cnt = 0;
		while (cycle_limit == 0 || cycle_cnt < cycle_limit) begin
			@(posedge okClk);
			cycle_cnt++;
		end
		$display("timeout: the run did not finish within %0d cycles", cycle_limit);
		$display("checks %0d, errors %0d", check_cnt, err_cnt);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		i_reset         = 1'b1;
		i_pipe_in_write = 1'b0;
		i_pipe_in_data  = '0;
		i_pipe_out_read = 1'b0;
		i_op_en         = 1'b0;
		i_wire_addr     = '0;
		err_cnt         = 0;
		check_cnt       = 0;
		cycle_limit     = 0;
		total_words     = 0;
		void'($urandom(32'hbb40caa0));

		foreach (rows[r]) begin
			total_words += sqz_pkg::CMD_WORDS;
			if (rows[r].op == sqz_pkg::OP_WRITE || rows[r].op == sqz_pkg::OP_READ)
				total_words += int'(rows[r].nblocks) * sqz_pkg::BLOCK_SIZE;
		end
		cycle_limit = total_words * 8 + 2000;

		apply_reset();
		check_value("o_irq", 32'(o_irq), 32'd0);
		check_value("o_pipe_out_valid", 32'(o_pipe_out_valid), 32'd0);
		check_value("o_pipe_out_ready", 32'(o_pipe_out_ready), 32'd0);
		check_value("o_pipe_in_ready", 32'(o_pipe_in_ready), 32'd1);

		// pipe-in throttle stays high up to 44 words
		for (int i = 0; i < 45; i++) begin
			push_word($urandom);
			check_value("o_pipe_in_ready", 32'(o_pipe_in_ready), 32'd1);
		end
		tick();
		check_value("o_pipe_in_ready after 45 words", 32'(o_pipe_in_ready), 32'd0);
		apply_reset();

		foreach (rows[r])
			run_row(rows[r]);

		repeat (4) tick();
		$display("checks %0d, errors %0d", check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- files.f
source/sqz_pkg.sv
source/pipe_fifo.sv
source/host_endpoints.sv
source/csb.sv
source/dma_port.sv
source/scratch_mem.sv
source/sqz_top.sv
dv/tb_sqz_top.sv

//--- Makefile
TOP = tb_sqz_top
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f files.f

run: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q -F "*** TEST PASSED ***" $(LOG)

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir $(LOG)
